// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timescale 1ns/100ps -j 0
TOP       = huffman_tb
FILELIST  = huffman.f
BUILD     = obj_dir
SIM       = $(BUILD)/V$(TOP)
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/huffman_pkg.sv
package huffman_pkg;

	// ============================================================
	// sizes
	// ============================================================
	localparam int num_symbols = 6;  // coded gray levels 1 to 6
	localparam int num_merges  = 5;  // merges to reach a single root

	// gray values that map onto symbols
	localparam logic [7:0] gray_sym_first = 8'd1;
	localparam logic [7:0] gray_sym_last  = 8'd6;

	// ============================================================
	// scalar types
	// ============================================================
	typedef logic [7:0]  count_t;      // wraps at 256
	typedef logic [10:0] weight_t;     // holds six full counts
	typedef logic [5:0]  sym_mask_t;   // bit i is symbol i+1
	typedef logic [2:0]  sym_index_t;  // symbol number 0 to 5
	typedef logic [7:0]  code_t;       // right-aligned code or mask

	// one element per symbol, element 0 is symbol 1
	typedef count_t [num_symbols-1:0] count_array_t;
	typedef code_t  [num_symbols-1:0] code_array_t;

	// ============================================================
	// control phases
	// ============================================================
	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_receive   = 3'd1,
		st_count_out = 3'd2,
		st_load      = 3'd3,
		st_merge     = 3'd4,
		st_code_out  = 3'd5,
		st_done      = 3'd6
	} ctrl_state_t;

endpackage

// File: huffman.f
+incdir+verification
common/huffman_pkg.sv
rtl/symbol_histogram.sv
rtl/huffman_control.sv
tree/node_list.sv
tree/code_builder.sv
rtl/huffman_top.sv
verification/huffman_tb.sv

// File: rtl/huffman_control.sv
`timescale 1ns/100ps

module huffman_control
	import huffman_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       gray_valid,
	output logic       load_en,
	output sym_index_t load_symbol,
	output logic       merge_en,
	output logic       cnt_valid,
	output logic       code_valid
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	sym_index_t  step;        // load symbol, then merge number
	logic        last_load;
	logic        last_merge;

	assign last_load  = (step == sym_index_t'(num_symbols - 1));
	assign last_merge = (step == sym_index_t'(num_merges - 1));

	// ============================================================
	// phase sequencing
	// ============================================================
	always_comb begin
		state_next = state;
		case (state)
			st_idle:
				if (gray_valid)
					state_next = st_receive;
			st_receive:
				if (!gray_valid)
					state_next = st_count_out;
			st_count_out:
				state_next = st_load;
			st_load:
				if (last_load)
					state_next = st_merge;
			st_merge:
				if (last_merge)
					state_next = st_code_out;
			st_code_out:
				state_next = st_done;
			st_done:
				state_next = st_done;  // held until reset
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	// step counter shared by load and merge phases
	always_ff @(posedge clk) begin
		if (reset) begin
			step <= '0;
		end else if (state == st_count_out || (state == st_load && last_load)) begin
			step <= '0;
		end else if (state == st_load || state == st_merge) begin
			step <= step + sym_index_t'(1);
		end
	end

	// ============================================================
	// strobes
	// ============================================================
	assign load_en     = (state == st_load);
	assign load_symbol = step;
	assign merge_en    = (state == st_merge);
	assign cnt_valid   = (state == st_count_out);
	assign code_valid  = (state == st_code_out);  // 12 cycles after cnt_valid

endmodule

// File: rtl/huffman_top.sv
`timescale 1ns/100ps

module huffman_top
	import huffman_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic [7:0]   gray_data,
	input  logic         gray_valid,
	output count_array_t cnt,
	output logic         cnt_valid,
	output code_array_t  hc,
	output code_array_t  m,
	output logic         code_valid
);

	logic       load_en;
	sym_index_t load_symbol;
	logic       merge_en;
	sym_mask_t  low_mask;   // set of the lowest node
	sym_mask_t  high_mask;  // set of the second lowest node

	symbol_histogram i_symbol_histogram (
		.clk        (clk),
		.reset      (reset),
		.gray_data  (gray_data),
		.gray_valid (gray_valid),
		.cnt        (cnt)
	);

	huffman_control i_huffman_control (
		.clk         (clk),
		.reset       (reset),
		.gray_valid  (gray_valid),
		.load_en     (load_en),
		.load_symbol (load_symbol),
		.merge_en    (merge_en),
		.cnt_valid   (cnt_valid),
		.code_valid  (code_valid)
	);

	node_list i_node_list (
		.clk         (clk),
		.reset       (reset),
		.cnt         (cnt),
		.load_en     (load_en),
		.load_symbol (load_symbol),
		.merge_en    (merge_en),
		.low_mask    (low_mask),
		.high_mask   (high_mask)
	);

	code_builder i_code_builder (
		.clk       (clk),
		.reset     (reset),
		.merge_en  (merge_en),
		.low_mask  (low_mask),
		.high_mask (high_mask),
		.hc        (hc),
		.m         (m)
	);

endmodule

// File: rtl/symbol_histogram.sv
`timescale 1ns/100ps

module symbol_histogram
	import huffman_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic [7:0]   gray_data,
	input  logic         gray_valid,
	output count_array_t cnt
);

	logic       seen;     // first valid sample arrived
	logic       closed;   // counts frozen once the stream ends
	logic       hit;
	sym_index_t sym;

	assign hit = gray_valid && !closed &&
	             (gray_data >= gray_sym_first) && (gray_data <= gray_sym_last);
	assign sym = sym_index_t'(gray_data - gray_sym_first);

	always_ff @(posedge clk) begin
		if (reset) begin
			seen   <= 1'b0;
			closed <= 1'b0;
			cnt    <= '0;
		end else begin
			if (gray_valid)
				seen <= 1'b1;
			if (seen && !gray_valid)
				closed <= 1'b1;  // same edge that enters count out
			if (hit)
				cnt[sym] <= cnt[sym] + count_t'(1);  // wraps at 256
		end
	end

endmodule

// File: tree/code_builder.sv
`timescale 1ns/100ps

module code_builder
	import huffman_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        merge_en,
	input  sym_mask_t   low_mask,
	input  sym_mask_t   high_mask,
	output code_array_t hc,
	output code_array_t m
);

	code_array_t free_bit;  // next unused bit per symbol

	// ============================================================
	// lowest zero bit of each mask
	// ============================================================
	always_comb begin
		for (int i = 0; i < num_symbols; i++)
			free_bit[i] = ~m[i] & (m[i] + code_t'(1));
	end

	// each merge puts one bit above the bits a symbol already has,
	// so the last merge lands in the msb of every code
	always_ff @(posedge clk) begin
		if (reset) begin
			hc <= '0;
			m  <= '0;
		end else if (merge_en) begin
			for (int i = 0; i < num_symbols; i++) begin
				if (low_mask[i]) begin
					hc[i] <= hc[i] | free_bit[i];  // low side gets 1
					m[i]  <= m[i] | free_bit[i];
				end else if (high_mask[i]) begin
					m[i]  <= m[i] | free_bit[i];  // high side gets 0
				end
			end
		end
	end

endmodule

// File: tree/node_list.sv
`timescale 1ns/100ps

module node_list
	import huffman_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  count_array_t cnt,
	input  logic         load_en,
	input  sym_index_t   load_symbol,
	input  logic         merge_en,
	output sym_mask_t    low_mask,
	output sym_mask_t    high_mask
);

	// slot 0 holds the lowest weight
	weight_t                slot_w [num_symbols];
	sym_mask_t              slot_s [num_symbols];
	logic [num_symbols-1:0] slot_occ;

	weight_t                base_w [num_symbols];  // list the new node joins
	sym_mask_t              base_s [num_symbols];
	logic [num_symbols-1:0] base_occ;
	weight_t                new_w;
	sym_mask_t              new_s;

	logic [num_symbols-1:0] ahead;  // slots that stay in front
	weight_t                next_w [num_symbols];
	sym_mask_t              next_s [num_symbols];
	logic [num_symbols-1:0] next_occ;

	// ============================================================
	// pick base list and new node
	// ============================================================
	always_comb begin
		if (merge_en) begin
			for (int i = 0; i < num_symbols - 2; i++) begin
				base_w[i]   = slot_w[i+2];  // drop the two lowest
				base_s[i]   = slot_s[i+2];
				base_occ[i] = slot_occ[i+2];
			end
			for (int i = num_symbols - 2; i < num_symbols; i++) begin
				base_w[i]   = '0;
				base_s[i]   = '0;
				base_occ[i] = 1'b0;
			end
			new_w = slot_w[0] + slot_w[1];
			new_s = slot_s[0] | slot_s[1];
		end else begin
			for (int i = 0; i < num_symbols; i++) begin
				base_w[i]   = slot_w[i];
				base_s[i]   = slot_s[i];
				base_occ[i] = slot_occ[i];
			end
			new_w = weight_t'(cnt[load_symbol]);
			new_s = sym_mask_t'(1) << load_symbol;
		end
	end

	// ============================================================
	// parallel compare and shift insert
	// ============================================================
	// new node goes ahead of equal weights, so only strictly lower stay in front
	always_comb begin
		for (int i = 0; i < num_symbols; i++)
			ahead[i] = base_occ[i] && (base_w[i] < new_w);

		if (ahead[0]) begin
			next_w[0]   = base_w[0];
			next_s[0]   = base_s[0];
			next_occ[0] = base_occ[0];
		end else begin
			next_w[0]   = new_w;
			next_s[0]   = new_s;
			next_occ[0] = 1'b1;
		end

		for (int i = 1; i < num_symbols; i++) begin
			if (ahead[i]) begin
				next_w[i]   = base_w[i];
				next_s[i]   = base_s[i];
				next_occ[i] = base_occ[i];
			end else if (ahead[i-1]) begin
				next_w[i]   = new_w;  // insert point
				next_s[i]   = new_s;
				next_occ[i] = 1'b1;
			end else begin
				next_w[i]   = base_w[i-1];
				next_s[i]   = base_s[i-1];
				next_occ[i] = base_occ[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			slot_occ <= '0;
		else if (load_en || merge_en)
			slot_occ <= next_occ;
	end

	always_ff @(posedge clk) begin
		if (load_en || merge_en) begin
			for (int i = 0; i < num_symbols; i++) begin
				slot_w[i] <= next_w[i];
				slot_s[i] <= next_s[i];
			end
		end
	end

	assign low_mask  = slot_occ[0] ? slot_s[0] : '0;
	assign high_mask = slot_occ[1] ? slot_s[1] : '0;

endmodule

// File: verification/huffman_cases.svh
// ============================================================
// one row per case with a column for each of symbols 1 to 6
// ============================================================
localparam int num_cases = 4;

// samples sent per symbol
localparam int case_samples [num_cases][num_symbols] = '{
	'{  1, 2, 4, 8, 16, 32},  // distinct weights forming one chain
	'{  5, 5, 5, 5,  5,  5},  // all tied
	'{  0, 3, 0, 3,  7,  1},  // zero counts and pairs
	'{258, 2, 9, 1,  1,  4}   // symbol 1 wraps to 2
};

// out of range samples mixed into each stream
localparam int case_bad [num_cases] = '{0, 4, 5, 3};

// counts seen on cnt at the cnt_valid pulse
localparam logic [7:0] case_cnt [num_cases][num_symbols] = '{
	'{8'd1, 8'd2, 8'd4, 8'd8, 8'd16, 8'd32},
	'{8'd5, 8'd5, 8'd5, 8'd5, 8'd5,  8'd5},
	'{8'd0, 8'd3, 8'd0, 8'd3, 8'd7,  8'd1},
	'{8'd2, 8'd2, 8'd9, 8'd1, 8'd1,  8'd4}
};

// right-aligned codes with the last merge in the msb
localparam logic [7:0] case_hc [num_cases][num_symbols] = '{
	'{8'h1f, 8'h1e, 8'h0e, 8'h06, 8'h02, 8'h00},
	'{8'h02, 8'h03, 8'h00, 8'h01, 8'h02, 8'h03},
	'{8'h16, 8'h03, 8'h17, 8'h04, 8'h00, 8'h0a},
	'{8'h01, 8'h00, 8'h01, 8'h02, 8'h03, 8'h01}
};

// valid code bits
localparam logic [7:0] case_m [num_cases][num_symbols] = '{
	'{8'h1f, 8'h1f, 8'h0f, 8'h07, 8'h03, 8'h01},
	'{8'h07, 8'h07, 8'h07, 8'h07, 8'h03, 8'h03},
	'{8'h1f, 8'h03, 8'h1f, 8'h07, 8'h01, 8'h0f},
	'{8'h07, 8'h0f, 8'h01, 8'h1f, 8'h1f, 8'h03}
};

// File: verification/huffman_tb.sv
`timescale 1ns/100ps

module huffman_tb
	import huffman_pkg::*;
();

	`include "huffman_cases.svh"

	localparam int clk_period   = 40;
	localparam int strobe_limit = 16;            // cycles to wait for a strobe
	localparam int late_cycles  = 2;             // input activity after the codes
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	logic         clk;
	logic         reset;
	logic [7:0]   gray_data;
	logic         gray_valid;
	count_array_t cnt;
	logic         cnt_valid;
	code_array_t  hc;
	code_array_t  m;
	logic         code_valid;

	logic [31:0] lfsr = 32'h1f78_7d91;
	int          errors;
	int          case_errors;
	int          failed_cases;

	huffman_top i_huffman_top (
		.clk        (clk),
		.reset      (reset),
		.gray_data  (gray_data),
		.gray_valid (gray_valid),
		.cnt        (cnt),
		.cnt_valid  (cnt_valid),
		.hc         (hc),
		.m          (m),
		.code_valid (code_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ============================================================
	// random bits and checks
	// ============================================================
	function automatic logic next_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ lfsr_taps;
		return out;
	endfunction

	function automatic int rand_bits(input int nbits);
		int result;
		result = 0;
		for (int i = 0; i < nbits; i++)
			result = (result << 1) | int'(next_bit());
		return result;
	endfunction

	function automatic int total_samples();
		int sum;
		sum = 0;
		for (int c = 0; c < num_cases; c++) begin
			sum += case_bad[c] + late_cycles;
			for (int i = 0; i < num_symbols; i++)
				sum += case_samples[c][i];
		end
		return sum;
	endfunction

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
			errors++;
			case_errors++;
		end
	endtask

	// outputs are sampled on the falling edge
	task automatic wait_for_strobe(input bit code, output int cycles);
		logic seen;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < strobe_limit) begin
			@(negedge clk);
			cycles++;
			seen = code ? code_valid : cnt_valid;
		end
		if (!seen) begin
			$display("ERROR at %0t ns: %s did not go high within %0d cycles",
			         $time, code ? "code_valid" : "cnt_valid", strobe_limit);
			errors++;
			case_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset      = 1'b1;
		gray_valid = 1'b0;
		gray_data  = 8'd0;
		repeat (4) @(posedge clk);
		#2;
		check_value("cnt_valid", int'(cnt_valid), 0);
		check_value("code_valid", int'(code_valid), 0);
		for (int i = 0; i < num_symbols; i++) begin
			check_value($sformatf("cnt[%0d]", i), int'(cnt[i]), 0);
			check_value($sformatf("hc[%0d]", i), int'(hc[i]), 0);
			check_value($sformatf("m[%0d]", i), int'(m[i]), 0);
		end
		reset = 1'b0;
	endtask

	task automatic check_results(input int c);
		for (int i = 0; i < num_symbols; i++) begin
			check_value($sformatf("hc[%0d]", i), int'(hc[i]), int'(case_hc[c][i]));
			check_value($sformatf("m[%0d]", i), int'(m[i]), int'(case_m[c][i]));
		end
	endtask

	// ============================================================
	// one case with shuffled stream, counts, codes and hold in st_done
	// ============================================================
	task automatic run_case(input int c);
		logic [7:0] stream [$];
		logic [7:0] value;
		int         k;
		int         cycles;
		case_errors = 0;
		for (int i = 0; i < num_symbols; i++)
			for (int n = 0; n < case_samples[c][i]; n++)
				stream.push_back(8'(i + 1));
		for (int n = 0; n < case_bad[c]; n++) begin
			value = 8'(rand_bits(8));
			if (value >= 8'd1 && value <= 8'd6)
				value = ~value;  // keep it out of range
			stream.push_back(value);
		end
		for (int j = stream.size() - 1; j > 0; j--) begin
			k         = rand_bits(16) % (j + 1);
			value     = stream[j];
			stream[j] = stream[k];
			stream[k] = value;
		end

		apply_reset();
		foreach (stream[j]) begin
			gray_valid = 1'b1;
			gray_data  = stream[j];
			@(posedge clk);
			#2;
		end
		gray_valid = 1'b0;

		// first edge with gray_valid low lands in the second sampled cycle
		wait_for_strobe(1'b0, cycles);
		check_value("cycles from last sample to cnt_valid", cycles, 2);
		for (int i = 0; i < num_symbols; i++)
			check_value($sformatf("cnt[%0d]", i), int'(cnt[i]), int'(case_cnt[c][i]));
		@(negedge clk);
		check_value("cnt_valid", int'(cnt_valid), 0);  // single cycle pulse
		wait_for_strobe(1'b1, cycles);
		check_value("cycles from cnt_valid to code_valid", cycles + 1, 12);
		check_results(c);

		// activity after the codes must change nothing
		@(posedge clk);
		#2;
		gray_valid = 1'b1;
		gray_data  = 8'd3;
		@(negedge clk);
		check_value("code_valid", int'(code_valid), 0);
		@(posedge clk);
		#2;
		gray_valid = 1'b0;
		repeat (2) @(negedge clk);  // a restarted stream would pulse cnt_valid here
		check_value("cnt_valid", int'(cnt_valid), 0);
		check_results(c);
		for (int i = 0; i < num_symbols; i++)
			check_value($sformatf("cnt[%0d]", i), int'(cnt[i]), int'(case_cnt[c][i]));

		if (case_errors != 0)
			failed_cases++;
		$display("case %0d: %0d samples, %0d failed checks", c, stream.size(), case_errors);
	endtask

	initial begin
		reset        = 1'b1;
		gray_valid   = 1'b0;
		gray_data    = 8'd0;
		errors       = 0;
		failed_cases = 0;
		for (int c = 0; c < num_cases; c++)
			run_case(c);
		$display("cases %0d, failed cases %0d, failed checks %0d",
		         num_cases, failed_cases, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// watchdog sized from the case table
	initial begin
		int limit;
		limit = total_samples() + 20 * num_cases;
		#(limit * clk_period);
		$display("TIMEOUT: the run did not end within %0d clock cycles", limit);
		$display("Result: FAILED");
		$finish;
	end

endmodule
